// ==== Makefile ====
# Verilator build and run of the issue stage testbench

TOP = tb_issue

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f *.sv *.svh
	verilator --binary --timing -f list.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== age_tracker.sv ====
// per-row age counters and oldest ready row selection
`timescale 1ns/1ps
`include "issue_cfg.svh"

module age_tracker
    import issue_pkg::*;
(
    input  logic                                          CLK,
    input  logic                                          nRST,
    input  fust_state_e [`ISSUE_NUM_FU-1:0]               state,
    input  logic        [`ISSUE_NUM_FU-1:0]               load,
    input  logic        [`ISSUE_NUM_FU-1:0]               rdy,
    output logic        [`ISSUE_NUM_FU-1:0][`ISSUE_AGE_W-1:0] ages,
    output logic        [`ISSUE_NUM_FU-1:0]               oldest
);

    logic [`ISSUE_NUM_FU-1:0][`ISSUE_AGE_W-1:0] next_ages;
    logic [`ISSUE_AGE_W-1:0]                    best_age;
    logic                                       found;

    always_comb begin
        for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
            if (load[i]) begin
                // freshly dispatched rows start at one
                next_ages[i] = `ISSUE_AGE_W'(1);
            end else if (state[i] == FUST_WAIT || state[i] == FUST_RDY) begin
                next_ages[i] = (ages[i] == '1) ? ages[i] : ages[i] + 1'b1;
            end else begin
                next_ages[i] = '0;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ages <= '0;
        end else begin
            ages <= next_ages;
        end
    end

    // strict compare keeps the lower index on a tie
    always_comb begin
        oldest   = '0;
        best_age = '0;
        found    = 1'b0;
        for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
            if (rdy[i] && (!found || ages[i] > best_age)) begin
                oldest    = '0;
                oldest[i] = 1'b1;
                best_age  = ages[i];
                found     = 1'b1;
            end
        end
    end

endmodule

// ==== fu_status_table.sv ====
// FUST row storage, loaded by dispatch
// producer tags are cleared when their unit completes
`timescale 1ns/1ps
`include "issue_cfg.svh"

module fu_status_table
    import issue_pkg::*;
(
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic      [`ISSUE_NUM_FU-1:0] load,
    input  regbits_t                      disp_rd,
    input  regbits_t                      disp_rs1,
    input  regbits_t                      disp_rs2,
    input  regbits_t                      disp_rs3,
    input  tag_t                          disp_t1,
    input  tag_t                          disp_t2,
    input  tag_t                          disp_t3,
    input  logic      [`ISSUE_NUM_FU-1:0] done,
    output fust_row_t [`ISSUE_NUM_FU-1:0] rows
);

    fust_row_t                      disp_row;
    fust_row_t [`ISSUE_NUM_FU-1:0]  next_rows;

    // incoming row, tags already checked against this cycle's completions
    always_comb begin
        disp_row.rd  = disp_rd;
        disp_row.rs1 = disp_rs1;
        disp_row.rs2 = disp_rs2;
        disp_row.rs3 = disp_rs3;
        disp_row.t1  = clear_tag(disp_t1, done);
        disp_row.t2  = clear_tag(disp_t2, done);
        disp_row.t3  = clear_tag(disp_t3, done);
    end

    always_comb begin
        for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
            if (load[i]) begin
                next_rows[i] = disp_row;
            end else begin
                next_rows[i]    = rows[i];
                next_rows[i].t1 = clear_tag(rows[i].t1, done);
                next_rows[i].t2 = clear_tag(rows[i].t2, done);
                next_rows[i].t3 = clear_tag(rows[i].t3, done);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            rows <= next_rows;
        end
    end

endmodule

// ==== fust_sequencer.sv ====
// per-row FUST state machines, ready logic, issue strobe
// and the write-after-read completion stall
`timescale 1ns/1ps
`include "issue_cfg.svh"

module fust_sequencer
    import issue_pkg::*;
(
    input  logic                                              CLK,
    input  logic                                              nRST,
    input  logic                                              disp_en,
    input  fu_e                                               disp_fu,
    input  fust_row_t   [`ISSUE_NUM_FU-1:0]                   rows,
    input  logic        [`ISSUE_NUM_FU-1:0]                   wb_done,
    input  logic                                              freeze,
    input  logic        [`ISSUE_NUM_FU-1:0]                   oldest,
    input  logic        [`ISSUE_NUM_FU-1:0][`ISSUE_AGE_W-1:0] ages,
    output fust_state_e [`ISSUE_NUM_FU-1:0]                   state,
    output logic        [`ISSUE_NUM_FU-1:0]                   rdy,
    output logic        [`ISSUE_NUM_FU-1:0]                   load,
    output logic        [`ISSUE_NUM_FU-1:0]                   done,
    output logic        [`ISSUE_NUM_FU-1:0]                   issue_sel,
    output logic        [`ISSUE_NUM_FU-1:0]                   wb_stall,
    output logic        [`ISSUE_NUM_FU-1:0]                   fust_busy
);

    fust_state_e [`ISSUE_NUM_FU-1:0] next_state;
    logic        [`ISSUE_NUM_FU-1:0] pending;

    always_comb begin
        for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
            pending[i]   = (state[i] == FUST_WAIT) || (state[i] == FUST_RDY);
            fust_busy[i] = (state[i] != FUST_EMPTY);
        end
    end

    // WAR stall: an older pending reader still needs the old value of rd
    // a reader whose tag points at this unit is a RAW consumer, not a hazard
    always_comb begin
        wb_stall = '0;
        for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
            if (state[i] == FUST_EX) begin
                // GEMM row never reads scalar registers
                for (int j = 0; j < int'(FU_GEMM); j++) begin
                    if (j != i && pending[j] && ages[j] > ages[i]) begin
                        if ((rows[j].rs1 == rows[i].rd && rows[j].t1 != tag_t'(i + 1)) ||
                            (rows[j].rs2 == rows[i].rd && rows[j].t2 != tag_t'(i + 1)))
                            wb_stall[i] = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
            done[i] = wb_done[i] && (state[i] == FUST_EX) && !wb_stall[i];
            // a row freed this cycle may take the new dispatch
            load[i] = disp_en && (int'(disp_fu) == i) &&
                      ((state[i] == FUST_EMPTY) || done[i]);
        end
    end

    // ready sees tags after this cycle's completions
    always_comb begin
        for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
            rdy[i] = pending[i] &&
                     (clear_tag(rows[i].t1, done) == '0) &&
                     (clear_tag(rows[i].t2, done) == '0);
            if (i == int'(FU_GEMM))
                rdy[i] = rdy[i] && (clear_tag(rows[i].t3, done) == '0);
        end
    end

    assign issue_sel = freeze ? '0 : oldest;

    always_comb begin
        for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
            next_state[i] = state[i];
            case (state[i])
                FUST_EMPTY: begin
                    if (load[i])
                        next_state[i] = FUST_WAIT;
                end
                FUST_WAIT: begin
                    if (issue_sel[i])
                        next_state[i] = FUST_EX;
                    else if (rdy[i])
                        next_state[i] = FUST_RDY;
                end
                FUST_RDY: begin
                    if (issue_sel[i])
                        next_state[i] = FUST_EX;
                end
                FUST_EX: begin
                    if (done[i])
                        next_state[i] = load[i] ? FUST_WAIT : FUST_EMPTY;
                end
                default: next_state[i] = FUST_EMPTY;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `ISSUE_NUM_FU; i++)
                state[i] <= FUST_EMPTY;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== issue.sv ====
// issue stage top: FUST, sequencer, age tracker and register file
// builds the issue word and holds the registered issue output under freeze
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue
    import issue_pkg::*;
(
    input  logic                     CLK,
    input  logic                     nRST,
    // dispatch
    input  logic                     disp_en,
    input  fu_e                      disp_fu,
    input  regbits_t                 disp_rd,
    input  regbits_t                 disp_rs1,
    input  regbits_t                 disp_rs2,
    input  regbits_t                 disp_rs3,
    input  tag_t                     disp_t1,
    input  tag_t                     disp_t2,
    input  tag_t                     disp_t3,
    output logic [`ISSUE_NUM_FU-1:0] fust_busy,
    // writeback
    input  logic [`ISSUE_NUM_FU-1:0] wb_done,
    input  logic                     wb_rw_en,
    input  regbits_t                 wb_rd,
    input  word_t                    wb_data,
    output logic [`ISSUE_NUM_FU-1:0] wb_stall,
    // control
    input  logic                     freeze,
    // issue
    output logic                     issue_valid,
    output fu_e                      issue_fu,
    output regbits_t                 issue_rd,
    output issue_opnd_u              issue_opnd
);

    fust_row_t   [`ISSUE_NUM_FU-1:0]                   rows;
    fust_state_e [`ISSUE_NUM_FU-1:0]                   state;
    logic        [`ISSUE_NUM_FU-1:0]                   rdy;
    logic        [`ISSUE_NUM_FU-1:0]                   load;
    logic        [`ISSUE_NUM_FU-1:0]                   done;
    logic        [`ISSUE_NUM_FU-1:0]                   issue_sel;
    logic        [`ISSUE_NUM_FU-1:0]                   oldest;
    logic        [`ISSUE_NUM_FU-1:0][`ISSUE_AGE_W-1:0] ages;

    fust_row_t   sel_row;
    fu_e         sel_fu;
    word_t       rdat1;
    word_t       rdat2;
    issue_opnd_u n_opnd;

    regfile i_regfile (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb_rw_en),
        .wsel  (wb_rd),
        .wdata (wb_data),
        .rsel1 (sel_row.rs1),
        .rsel2 (sel_row.rs2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    fu_status_table i_fust (
        .CLK      (CLK),
        .nRST     (nRST),
        .load     (load),
        .disp_rd  (disp_rd),
        .disp_rs1 (disp_rs1),
        .disp_rs2 (disp_rs2),
        .disp_rs3 (disp_rs3),
        .disp_t1  (disp_t1),
        .disp_t2  (disp_t2),
        .disp_t3  (disp_t3),
        .done     (done),
        .rows     (rows)
    );

    fust_sequencer i_seq (
        .CLK       (CLK),
        .nRST      (nRST),
        .disp_en   (disp_en),
        .disp_fu   (disp_fu),
        .rows      (rows),
        .wb_done   (wb_done),
        .freeze    (freeze),
        .oldest    (oldest),
        .ages      (ages),
        .state     (state),
        .rdy       (rdy),
        .load      (load),
        .done      (done),
        .issue_sel (issue_sel),
        .wb_stall  (wb_stall),
        .fust_busy (fust_busy)
    );

    age_tracker i_age (
        .CLK    (CLK),
        .nRST   (nRST),
        .state  (state),
        .load   (load),
        .rdy    (rdy),
        .ages   (ages),
        .oldest (oldest)
    );

    // issue_sel is one-hot or zero
    always_comb begin
        sel_row = '0;
        sel_fu  = FU_ALU;
        for (int i = 0; i < `ISSUE_NUM_FU; i++) begin
            if (issue_sel[i]) begin
                sel_row = rows[i];
                sel_fu  = fu_e'(3'(i));
            end
        end
    end

    always_comb begin
        n_opnd = '0;
        if (sel_fu == FU_GEMM) begin
            // matrix selectors ride in the low nibble of the source fields
            n_opnd.matrix.ms1 = sel_row.rs1[3:0];
            n_opnd.matrix.ms2 = sel_row.rs2[3:0];
            n_opnd.matrix.ms3 = sel_row.rs3[3:0];
        end else begin
            n_opnd.scalar.rdat1 = rdat1;
            n_opnd.scalar.rdat2 = rdat2;
        end
    end

    // freeze holds every issue output, valid included
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
            issue_fu    <= FU_ALU;
            issue_rd    <= '0;
            issue_opnd  <= '0;
        end else if (!freeze) begin
            issue_valid <= |issue_sel;
            if (|issue_sel) begin
                issue_fu   <= sel_fu;
                issue_rd   <= sel_row.rd;
                issue_opnd <= n_opnd;
            end
        end
    end

endmodule

// ==== issue_cases.txt ====
# R rd data | D fu rd rs1 rs2 rs3 t1 t2 t3 | W done rw_en rd data | F freeze | I cycles | G gap
# E fu rd opnd (expected issue) | N (no issue) | S stall mask | B busy mask, all in hex
R 03 11111111
R 04 22222222
D 0 05 03 04 00 0 0 0
I 1
E 0 05 1111111122222222
D 1 06 07 03 00 1 0 0
I 2
N
W 01 1 07 33333333
E 1 06 3333333311111111
W 02 0 00 00000000
G
D 3 0a 01 02 00 0 0 0
I 1
E 3 0a 0000000000000000
D 2 08 03 04 00 4 0 0
I 1
D 0 09 04 03 00 0 4 0
I 1
W 08 0 00 00000000
E 2 08 1111111122222222
E 0 09 2222222211111111
W 05 0 00 00000000
G
D 1 0b 00 00 00 0 0 0
I 1
E 1 0b 0000000000000000
D 2 0c 03 03 00 2 0 0
D 0 0d 04 04 00 2 0 0
I 20
W 02 0 00 00000000
E 0 0d 2222222222222222
E 2 0c 1111111111111111
B 05
D 0 1f 00 00 00 0 0 0
D 5 1e 00 00 00 0 0 0
N
B 05
W 05 0 00 00000000
I 1
B 00
G
D 0 0e 03 04 00 0 0 0
D 2 0f 04 03 00 0 0 0
F 1
E 0 0e 1111111122222222
E 0 0e 1111111122222222
F 0
E 2 0f 2222222211111111
W 05 0 00 00000000
G
D 4 10 01 02 03 0 0 0
I 1
E 4 10 0000000000000123
D 1 11 03 00 00 0 5 0
D 0 03 00 00 00 0 0 0
I 1
E 0 03 0000000000000000
S 01
W 01 0 00 00000000
S 01
I 1
S 01
W 10 0 00 00000000
E 1 11 1111111100000000
S 00
W 03 0 00 00000000
I 1
B 00

// ==== issue_cfg.svh ====
// sizing macros of the issue stage
// unit count, age counter width, scalar register count and word width
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// one FUST row per unit
// ALU, LDST, branch, matrix LDST, GEMM
`define ISSUE_NUM_FU 5

// row age counter, saturates at all ones
`define ISSUE_AGE_W 4

// scalar register file depth, register zero reads as zero
`define ISSUE_NREGS 32

// scalar data word
`define ISSUE_WORD_W 32

`endif

// ==== issue_pkg.sv ====
// issue stage types: unit index, row state, tags, FUST row and issue operand union
// plus the tag clear helper shared by the table and the sequencer
`include "issue_cfg.svh"

package issue_pkg;

    typedef enum logic [2:0] {
        FU_ALU    = 3'd0,
        FU_LDST   = 3'd1,
        FU_BRANCH = 3'd2,
        FU_MLDST  = 3'd3,
        FU_GEMM   = 3'd4
    } fu_e;

    typedef enum logic [1:0] {
        FUST_EMPTY,
        FUST_WAIT,
        FUST_RDY,
        FUST_EX
    } fust_state_e;

    typedef logic [4:0] regbits_t;
    typedef logic [`ISSUE_WORD_W-1:0] word_t;

    // 0 means available, k+1 means waiting on unit k
    typedef logic [2:0] tag_t;

    // rs3 and t3 only matter in the GEMM row
    // GEMM matrix selectors live in the low nibble of rs1, rs2, rs3
    typedef struct packed {
        regbits_t rd;
        regbits_t rs1;
        regbits_t rs2;
        regbits_t rs3;
        tag_t     t1;
        tag_t     t2;
        tag_t     t3;
    } fust_row_t;

    // the issued unit picks the view
    typedef union packed {
        struct packed {
            word_t rdat1;
            word_t rdat2;
        } scalar;
        struct packed {
            logic [51:0] pad;
            logic [3:0]  ms1;
            logic [3:0]  ms2;
            logic [3:0]  ms3;
        } matrix;
    } issue_opnd_u;

    // a tag whose producer completes this cycle counts as cleared
    function automatic tag_t clear_tag(tag_t t, logic [`ISSUE_NUM_FU-1:0] done);
        tag_t res;
        res = t;
        for (int k = 0; k < `ISSUE_NUM_FU; k++) begin
            if (done[k] && t == tag_t'(k + 1))
                res = '0;
        end
        return res;
    endfunction

endpackage

// ==== list.f ====
+incdir+.
issue_pkg.sv
regfile.sv
fu_status_table.sv
age_tracker.sv
fust_sequencer.sv
issue.sv
tb_issue.sv

// ==== regfile.sv ====
// scalar register file, two read ports with write-through bypass
`timescale 1ns/1ps
`include "issue_cfg.svh"

module regfile
    import issue_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     wen,
    input  regbits_t wsel,
    input  word_t    wdata,
    input  regbits_t rsel1,
    input  regbits_t rsel2,
    output word_t    rdat1,
    output word_t    rdat2
);

    word_t [`ISSUE_NREGS-1:0] regs;
    logic                     wr_live;

    // register zero is never written
    assign wr_live = wen && (wsel != '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '0;
        end else if (wr_live) begin
            regs[wsel] <= wdata;
        end
    end

    // same-cycle write shows up on the read ports
    always_comb begin
        rdat1 = regs[rsel1];
        rdat2 = regs[rsel2];
        if (wr_live && wsel == rsel1)
            rdat1 = wdata;
        if (wr_live && wsel == rsel2)
            rdat2 = wdata;
    end

endmodule

// ==== tb_issue.sv ====
// testbench for the issue stage
// reads commands and expected values from issue_cases.txt, compares issue and stall results
`timescale 1ns/1ps
`include "issue_cfg.svh"

module tb_issue
    import issue_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int MARGIN_CYCLES = 50;

    logic                     CLK;
    logic                     nRST;
    logic                     disp_en;
    fu_e                      disp_fu;
    regbits_t                 disp_rd;
    regbits_t                 disp_rs1;
    regbits_t                 disp_rs2;
    regbits_t                 disp_rs3;
    tag_t                     disp_t1;
    tag_t                     disp_t2;
    tag_t                     disp_t3;
    logic [`ISSUE_NUM_FU-1:0] fust_busy;
    logic [`ISSUE_NUM_FU-1:0] wb_done;
    logic                     wb_rw_en;
    regbits_t                 wb_rd;
    word_t                    wb_data;
    logic [`ISSUE_NUM_FU-1:0] wb_stall;
    logic                     freeze;
    logic                     issue_valid;
    fu_e                      issue_fu;
    regbits_t                 issue_rd;
    issue_opnd_u              issue_opnd;

    string   lines[$];
    int      limit_cycles = 0;

    issue i_issue (
        .CLK         (CLK),
        .nRST        (nRST),
        .disp_en     (disp_en),
        .disp_fu     (disp_fu),
        .disp_rd     (disp_rd),
        .disp_rs1    (disp_rs1),
        .disp_rs2    (disp_rs2),
        .disp_rs3    (disp_rs3),
        .disp_t1     (disp_t1),
        .disp_t2     (disp_t2),
        .disp_t3     (disp_t3),
        .fust_busy   (fust_busy),
        .wb_done     (wb_done),
        .wb_rw_en    (wb_rw_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .wb_stall    (wb_stall),
        .freeze      (freeze),
        .issue_valid (issue_valid),
        .issue_fu    (issue_fu),
        .issue_rd    (issue_rd),
        .issue_opnd  (issue_opnd)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic fail_now();
        $display("TB FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_fu(string name, fu_e got, fu_e exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_reg(string name, regbits_t got, regbits_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_opnd(string name, issue_opnd_u got, issue_opnd_u exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_mask(string name, logic [`ISSUE_NUM_FU-1:0] got,
                              logic [`ISSUE_NUM_FU-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    // strobes drop back to idle unless a command raises them again
    task automatic next_cycle();
        @(posedge CLK);
        disp_en  <= 1'b0;
        wb_done  <= '0;
        wb_rw_en <= 1'b0;
    endtask

    task automatic load_cases();
        int    fd;
        string line;
        fd = $fopen("issue_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open issue_cases.txt for reading");
            fail_now();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
                lines.push_back(line);
        end
        $fclose(fd);
    endtask

    // upper bound of cycles for the whole case list
    function automatic int count_cycles();
        int total;
        int n;
        total = 0;
        foreach (lines[i]) begin
            if (lines[i].getc(0) == "I") begin
                void'($sscanf(lines[i], "I %d", n));
                total += n;
            end else if (lines[i].getc(0) == "G") begin
                total += 4;
            end else begin
                total += 1;
            end
        end
        return total;
    endfunction

    task automatic run_line(string line);
        logic [31:0] f[8];
        logic [63:0] o;
        int          n;
        case (line.getc(0))
            "R": begin
                void'($sscanf(line, "R %h %h", f[0], f[1]));
                next_cycle();
                wb_rw_en <= 1'b1;
                wb_rd    <= regbits_t'(f[0]);
                wb_data  <= f[1];
            end
            "D": begin
                void'($sscanf(line, "D %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]));
                next_cycle();
                disp_en  <= 1'b1;
                disp_fu  <= fu_e'(f[0][2:0]);
                disp_rd  <= regbits_t'(f[1]);
                disp_rs1 <= regbits_t'(f[2]);
                disp_rs2 <= regbits_t'(f[3]);
                disp_rs3 <= regbits_t'(f[4]);
                disp_t1  <= tag_t'(f[5]);
                disp_t2  <= tag_t'(f[6]);
                disp_t3  <= tag_t'(f[7]);
            end
            "W": begin
                void'($sscanf(line, "W %h %h %h %h", f[0], f[1], f[2], f[3]));
                next_cycle();
                wb_done  <= f[0][`ISSUE_NUM_FU-1:0];
                wb_rw_en <= f[1][0];
                wb_rd    <= regbits_t'(f[2]);
                wb_data  <= f[3];
            end
            "F": begin
                void'($sscanf(line, "F %h", f[0]));
                next_cycle();
                freeze <= f[0][0];
            end
            "I": begin
                void'($sscanf(line, "I %d", n));
                repeat (n) next_cycle();
            end
            "G": begin
                n = 1 + int'($urandom % 4);
                repeat (n) next_cycle();
            end
            "E": begin
                void'($sscanf(line, "E %h %h %h", f[0], f[1], o));
                next_cycle();
                @(negedge CLK);
                if (issue_valid !== 1'b1) begin
                    $display("expected issue from unit %0d did not arrive at its edge", f[0]);
                    fail_now();
                end
                check_fu("issue_fu", issue_fu, fu_e'(f[0][2:0]));
                check_reg("issue_rd", issue_rd, regbits_t'(f[1]));
                check_opnd("issue_opnd", issue_opnd, issue_opnd_u'(o));
            end
            "N": begin
                next_cycle();
                @(negedge CLK);
                if (issue_valid !== 1'b0) begin
                    $display("ERROR issue_valid got %h expected %h", issue_valid, 1'b0);
                    fail_now();
                end
            end
            "S": begin
                void'($sscanf(line, "S %h", f[0]));
                @(negedge CLK);
                check_mask("wb_stall", wb_stall, f[0][`ISSUE_NUM_FU-1:0]);
            end
            "B": begin
                void'($sscanf(line, "B %h", f[0]));
                @(negedge CLK);
                check_mask("fust_busy", fust_busy, f[0][`ISSUE_NUM_FU-1:0]);
            end
            default: begin
                $display("unknown command in case file: %s", line);
                fail_now();
            end
        endcase
    endtask

    initial begin
        wait (limit_cycles != 0);
        #(CLK_PERIOD * limit_cycles);
        $display("run did not finish within the expected time");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'ha3b));
        nRST     <= 1'b0;
        disp_en  <= 1'b0;
        disp_fu  <= FU_ALU;
        disp_rd  <= '0;
        disp_rs1 <= '0;
        disp_rs2 <= '0;
        disp_rs3 <= '0;
        disp_t1  <= '0;
        disp_t2  <= '0;
        disp_t3  <= '0;
        wb_done  <= '0;
        wb_rw_en <= 1'b0;
        wb_rd    <= '0;
        wb_data  <= '0;
        freeze   <= 1'b0;
        load_cases();
        limit_cycles = count_cycles() + RESET_CYCLES + MARGIN_CYCLES;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        foreach (lines[i])
            run_line(lines[i]);
        next_cycle();
        $display("TB PASSED");
        $finish;
    end

endmodule
